/* hw/codec_rx_cfg.svh */
// build-time sizing of the I2S receive path
// word width must exceed sample width, the rounder drops the difference
// fifo depth must be a power of two and at least 2 (pointers wrap freely)
// strobe position must stay below the shortest BCLK period in xclk cycles
`ifndef CODEC_RX_CFG_SVH
`define CODEC_RX_CFG_SVH

// serial word from the codec ADC, MSB first
`define CODEC_RX_WORD_W 24

// PCM sample handed to the system
`define CODEC_RX_SAMPLE_W 16

// BCLK rises between the LRCLK edge and the MSB
// 1 for standard I2S, 0 would mean left-justified timing
`define CODEC_RX_BIT_DELAY 1

// xclk cycles after a synchronized BCLK rise where DIN is taken
`define CODEC_RX_STROBE 0

// stereo frames buffered toward the system
`define CODEC_RX_FIFO_DEPTH 4

`endif // CODEC_RX_CFG_SVH

/* hw/codec_rx_pkg.sv */
// shared types of the I2S receive path
// widths come from codec_rx_cfg.svh, so every user sees the same layout
// stereo_frame_t packs left in the upper half and right in the lower half
`default_nettype none

`include "codec_rx_cfg.svh"

package codec_rx_pkg;

  // LRCLK level as seen on the wire: low is left, high is right
  typedef enum logic
  {
    LEFT  = 1'b0,
    RIGHT = 1'b1
  } chan_e;

  // one raw channel word straight off the shift register
  typedef struct packed
  {
    chan_e                        chan;
    logic [`CODEC_RX_WORD_W-1:0]  data;   // two's complement, MSB first on the wire
  } i2s_word_t;

  // one rounded sample, channel tag carried along
  typedef struct packed
  {
    chan_e                               chan;
    logic signed [`CODEC_RX_SAMPLE_W-1:0] pcm;
  } pcm_sample_t;

  // left/right pair as delivered to the system
  typedef struct packed
  {
    logic signed [`CODEC_RX_SAMPLE_W-1:0] left;   // upper half
    logic signed [`CODEC_RX_SAMPLE_W-1:0] right;  // lower half
  } stereo_frame_t;

endpackage : codec_rx_pkg

`default_nettype wire

/* hw/i2s_deserializer.sv */
// I2S slave receiver, oversampled in the xclk domain
// BCLK high and low must each last at least 4 xclk cycles
// a slot needs 24 + bit delay BCLK rises, later bits are ignored
// nothing is captured until the first LRCLK edge after reset
// word_valid is a bare one-cycle pulse, the source cannot be stalled
`timescale 1ns/1ps
`default_nettype none

`include "codec_rx_cfg.svh"

module i2s_deserializer
(
  input  logic                    xclk,
  input  logic                    xrst,
  input  logic                    bclk,        // async
  input  logic                    lrclk,       // async
  input  logic                    din,         // async, changes on BCLK fall
  output codec_rx_pkg::i2s_word_t word,
  output logic                    word_valid
);
  import codec_rx_pkg::*;

  localparam int WW      = `CODEC_RX_WORD_W;
  localparam int CAP_CNT = WW + `CODEC_RX_BIT_DELAY;  // rise count holding the LSB
  localparam int BC_W    = $clog2(CAP_CNT + 2);       // room to park above CAP_CNT
  localparam int STB_W   = 8;

  localparam logic [BC_W-1:0]  CAP_POS = BC_W'(CAP_CNT);
  localparam logic [STB_W-1:0] STB_POS = STB_W'(`CODEC_RX_STROBE);

  logic [2:0]       bclk_sync;   // [0] may go metastable, [2] is the settled copy
  logic [2:0]       lrclk_sync;
  logic [2:0]       din_sync;
  logic             bclk_rise;
  logic             lr_edge;
  logic             strobe;
  logic [STB_W-1:0] stb_cnt;     // xclk cycles since the last BCLK rise
  logic [BC_W-1:0]  bit_cnt;     // BCLK rises since the last LRCLK edge
  logic [WW-1:0]    shift_reg;
  logic [WW-1:0]    shift_nxt;

  // three-flop synchronizers, all three lines go through the same depth
  always_ff @(posedge xclk)
  begin
    if (xrst)
    begin
      bclk_sync  <= '0;
      lrclk_sync <= '0;
      din_sync   <= '0;
    end
    else
    begin
      bclk_sync  <= {bclk_sync[1:0], bclk};
      lrclk_sync <= {lrclk_sync[1:0], lrclk};
      din_sync   <= {din_sync[1:0], din};
    end
  end

  assign bclk_rise = bclk_sync[1] & ~bclk_sync[2];
  assign lr_edge   = lrclk_sync[1] ^ lrclk_sync[2];  // either direction starts a slot

  // position inside the BCLK period, parks at max if BCLK stops
  always_ff @(posedge xclk)
  begin
    if (xrst)
      stb_cnt <= '1;  // no strobe before the first rise
    else if (bclk_rise)
      stb_cnt <= '0;
    else if (stb_cnt != '1)
      stb_cnt <= stb_cnt + 1'b1;
  end

  assign strobe = (stb_cnt == STB_POS);

  // bit counter saturates so a long slot never captures twice
  always_ff @(posedge xclk)
  begin
    if (xrst)
      bit_cnt <= '1;  // wait for a real LRCLK edge
    else if (lr_edge)
      bit_cnt <= '0;
    else if (bclk_rise && (bit_cnt != '1))
      bit_cnt <= bit_cnt + 1'b1;
  end

  // msb first, so shift toward the top
  assign shift_nxt = {shift_reg[WW-2:0], din_sync[2]};

  always_ff @(posedge xclk)
  begin
    if (strobe)
      shift_reg <= shift_nxt;
  end

  // capture on the strobe that takes the LSB, bit of this cycle included
  always_ff @(posedge xclk)
  begin
    if (strobe && (bit_cnt == CAP_POS))
    begin
      word.data <= shift_nxt;
      word.chan <= lrclk_sync[2] ? RIGHT : LEFT;  // level of the slot just finished
    end
  end

  always_ff @(posedge xclk)
  begin
    if (xrst)
      word_valid <= 1'b0;
    else
      word_valid <= strobe && (bit_cnt == CAP_POS);
  end

  // one word per slot: strobe and counter together must never repeat a capture
  assert property (@(posedge xclk) disable iff (xrst) word_valid |=> !word_valid)
    else $error("word_valid high on two consecutive cycles");

endmodule : i2s_deserializer

`default_nettype wire

/* hw/sample_rounder.sv */
// 24 to 16 bit reduction, round half up, one register stage
// positive overflow of the rounding add saturates to the largest sample
// negative words cannot overflow, so there is no negative clamp
`timescale 1ns/1ps
`default_nettype none

`include "codec_rx_cfg.svh"

module sample_rounder
(
  input  logic                      xclk,
  input  logic                      xrst,
  input  codec_rx_pkg::i2s_word_t   word,
  input  logic                      word_valid,
  output codec_rx_pkg::pcm_sample_t sample,
  output logic                      sample_valid   // word_valid delayed by one
);

  localparam int WW   = `CODEC_RX_WORD_W;
  localparam int SW   = `CODEC_RX_SAMPLE_W;
  localparam int DROP = WW - SW;                    // bits thrown away

  localparam logic [WW-1:0]        HALF    = WW'(1) << (DROP - 1);  // half an output lsb
  localparam logic signed [SW-1:0] PCM_MAX = {1'b0, {(SW-1){1'b1}}};

  logic [WW-1:0] sum;
  logic          sat;

  assign sum = word.data + HALF;  // may wrap only for the top positive words
  // positive and every kept bit below the sign set -> the add would carry into the sign
  assign sat = ~word.data[WW-1] & (&word.data[WW-2 -: SW]);

  always_ff @(posedge xclk)
  begin
    if (word_valid)
    begin
      sample.chan <= word.chan;                     // tag passes straight through
      sample.pcm  <= sat ? PCM_MAX : $signed(sum[WW-1 -: SW]);
    end
  end

  always_ff @(posedge xclk)
  begin
    if (xrst)
      sample_valid <= 1'b0;
    else
      sample_valid <= word_valid;
  end

  // full scale positive out means the word going in was positive
  assert property (@(posedge xclk) disable iff (xrst)
    (sample_valid && (sample.pcm == PCM_MAX)) |-> !$past(word.data[WW-1]))
    else $error("full scale positive sample from a negative word");

endmodule : sample_rounder

`default_nettype wire

/* hw/stereo_framer.sv */
// pairs a left sample with the next right sample
// the frame is offered for one cycle only, a refused frame is lost
// overrun_cnt saturates at 255 and clears only on reset
// a right sample with no left stored is dropped silently (start-up case)
`timescale 1ns/1ps
`default_nettype none

`include "codec_rx_cfg.svh"

module stereo_framer
(
  input  logic                        xclk,
  input  logic                        xrst,
  input  codec_rx_pkg::pcm_sample_t   sample,
  input  logic                        sample_valid,
  output codec_rx_pkg::stereo_frame_t frame,
  output logic                        frame_valid,
  input  logic                        frame_ready,
  output logic [7:0]                  overrun_cnt
);
  import codec_rx_pkg::*;

  localparam int SW = `CODEC_RX_SAMPLE_W;

  logic signed [SW-1:0] left_pcm;   // waiting left half
  logic                 left_full;  // left_pcm holds a sample not yet paired
  logic                 take_left;
  logic                 take_right;

  assign take_left  = sample_valid && (sample.chan == LEFT);
  assign take_right = sample_valid && (sample.chan == RIGHT) && left_full;

  always_ff @(posedge xclk)
  begin
    if (xrst)
      left_full <= 1'b0;
    else if (take_left)
      left_full <= 1'b1;  // a second left simply replaces the first
    else if (take_right)
      left_full <= 1'b0;
  end

  always_ff @(posedge xclk)
  begin
    if (take_left)
      left_pcm <= sample.pcm;
  end

  // frame built on the right sample, offered the next cycle
  always_ff @(posedge xclk)
  begin
    if (take_right)
    begin
      frame.left  <= left_pcm;
      frame.right <= sample.pcm;
    end
  end

  always_ff @(posedge xclk)
  begin
    if (xrst)
      frame_valid <= 1'b0;
    else
      frame_valid <= take_right;  // single cycle, no holding
  end

  // fifo full on the offer cycle costs one frame
  always_ff @(posedge xclk)
  begin
    if (xrst)
      overrun_cnt <= '0;
    else if (frame_valid && !frame_ready && (overrun_cnt != 8'hFF))
      overrun_cnt <= overrun_cnt + 1'b1;
  end

  // a frame only ever closes on a right sample one cycle earlier
  assert property (@(posedge xclk) disable iff (xrst)
    frame_valid |-> $past(sample_valid && (sample.chan == RIGHT)))
    else $error("frame_valid without a preceding right sample");

endmodule : stereo_framer

`default_nettype wire

/* hw/frame_fifo.sv */
// small synchronous FIFO of stereo frames, valid/ready on both ports
// depth from CODEC_RX_FIFO_DEPTH, power of two and at least 2
// out_frame is read straight from the array at the read pointer
// push and pop may share a cycle but a full fifo refuses any push
`timescale 1ns/1ps
`default_nettype none

`include "codec_rx_cfg.svh"

module frame_fifo
(
  input  logic                        xclk,
  input  logic                        xrst,
  input  codec_rx_pkg::stereo_frame_t in_frame,
  input  logic                        in_valid,
  output logic                        in_ready,    // not full
  output codec_rx_pkg::stereo_frame_t out_frame,
  output logic                        out_valid,   // not empty
  input  logic                        out_ready
);
  import codec_rx_pkg::*;

  localparam int DEPTH = `CODEC_RX_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);
  localparam int CW    = $clog2(DEPTH + 1);

  localparam logic [CW-1:0] FULL = CW'(DEPTH);

  stereo_frame_t mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;   // frames held
  logic          push;
  logic          pop;

  assign in_ready  = (count != FULL);
  assign out_valid = (count != '0);
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;
  assign out_frame = mem[rd_ptr];

  always_ff @(posedge xclk)
  begin
    if (push)
      mem[wr_ptr] <= in_frame;
  end

  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge xclk)
  begin
    if (xrst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // none, or one in and one out
      endcase
    end
  end

  // full fifo never advances the write side, not even on a pop cycle
  assert property (@(posedge xclk) disable iff (xrst)
    (count == FULL) |=> (wr_ptr == $past(wr_ptr)))
    else $error("push into a full frame fifo");

  // empty fifo never advances the read side
  assert property (@(posedge xclk) disable iff (xrst)
    (count == '0) |=> (rd_ptr == $past(rd_ptr)))
    else $error("pop from an empty frame fifo");

endmodule : frame_fifo

`default_nettype wire

/* hw/codec_rx_top.sv */
// receive side of the codec interface: I2S in, stereo PCM frames out
// bclk, lrclk and din may be fully asynchronous to xclk
// BCLK must run at no more than one eighth of xclk
// frames refused by a full fifo are lost and show up in overrun_cnt
`timescale 1ns/1ps
`default_nettype none

module codec_rx_top
(
  input  logic                        xclk,
  input  logic                        xrst,
  input  logic                        bclk,
  input  logic                        lrclk,
  input  logic                        din,
  output codec_rx_pkg::stereo_frame_t out_frame,
  output logic                        out_valid,
  input  logic                        out_ready,
  output logic [7:0]                  overrun_cnt
);
  import codec_rx_pkg::*;

  i2s_word_t     word;          // raw 24 bit channel word
  logic          word_valid;
  pcm_sample_t   sample;        // rounded, still tagged by channel
  logic          sample_valid;
  stereo_frame_t frame;         // paired left/right
  logic          frame_valid;
  logic          frame_ready;

  i2s_deserializer u_deser (
    .xclk        (xclk),
    .xrst        (xrst),
    .bclk        (bclk),
    .lrclk       (lrclk),
    .din         (din),
    .word        (word),
    .word_valid  (word_valid)
  );

  sample_rounder u_round (
    .xclk         (xclk),
    .xrst         (xrst),
    .word         (word),
    .word_valid   (word_valid),
    .sample       (sample),
    .sample_valid (sample_valid)
  );

  stereo_framer u_framer (
    .xclk         (xclk),
    .xrst         (xrst),
    .sample       (sample),
    .sample_valid (sample_valid),
    .frame        (frame),
    .frame_valid  (frame_valid),
    .frame_ready  (frame_ready),
    .overrun_cnt  (overrun_cnt)
  );

  frame_fifo u_fifo (
    .xclk      (xclk),
    .xrst      (xrst),
    .in_frame  (frame),
    .in_valid  (frame_valid),
    .in_ready  (frame_ready),
    .out_frame (out_frame),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule : codec_rx_top

`default_nettype wire

/* verif/codec_rx_tb.sv */
// testbench for codec_rx_top: bit-bangs I2S slots and checks the stereo frames
// BCLK toggles every 4 xclk cycles, 32 BCLK periods per slot, one-bit delay
// expected samples come from the round-half-up rule with positive saturation
// fifo occupancy is modelled per row to predict kept and dropped frames
// random rows use a 32-bit Fibonacci LFSR, one step per bit taken
`timescale 1ns/1ps
`default_nettype none

`include "codec_rx_cfg.svh"

module codec_rx_tb;
  import codec_rx_pkg::*;

  localparam int WW      = `CODEC_RX_WORD_W;
  localparam int SW      = `CODEC_RX_SAMPLE_W;
  localparam int DEPTH   = `CODEC_RX_FIFO_DEPTH;
  localparam int SLOT    = 32;                      // BCLK periods per channel slot
  localparam int N_FIXED = 12;
  localparam int N_ROWS  = 18;                      // fixed rows plus random ones
  localparam int TIMEOUT = N_ROWS * 64 * 8 + 2000;  // xclk cycles

  localparam logic [WW-1:0]        HALF    = WW'(1) << (WW - SW - 1);
  localparam logic signed [SW-1:0] PCM_MAX = {1'b0, {(SW-1){1'b1}}};

  typedef struct packed
  {
    logic [WW-1:0] left24;
    logic [WW-1:0] right24;
    logic          ready;    // out_ready level while this frame is sent
    stereo_frame_t exp;
  } row_t;

  logic          xclk;
  logic          xrst;
  logic          bclk;
  logic          lrclk;
  logic          din;
  logic          out_ready;
  stereo_frame_t out_frame;
  logic          out_valid;
  logic [7:0]    overrun_cnt;

  row_t          rows[$];
  stereo_frame_t exp_q[$];     // frames the fifo should deliver, in order
  logic [31:0]   lfsr;
  int            n_checks;
  int            n_errors;
  int            exp_overrun;
  int            occ;          // modelled fifo fill
  int            cycle_cnt;

  codec_rx_top codec_rx_top_i (
    .xclk        (xclk),
    .xrst        (xrst),
    .bclk        (bclk),
    .lrclk       (lrclk),
    .din         (din),
    .out_frame   (out_frame),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .overrun_cnt (overrun_cnt)
  );

  initial xclk = 1'b0;
  always #20 xclk = ~xclk;  // 40 ns period

  // upper bits of word + half lsb, clamp when a positive word wraps into the sign
  function automatic logic signed [SW-1:0] round_word(input logic [WW-1:0] w);
    logic [WW-1:0] s;
    s = w + HALF;
    if (!w[WW-1] && s[WW-1])
      return PCM_MAX;
    return s[WW-1 -: SW];
  endfunction

  // taps 32,22,2,1
  function automatic logic [WW-1:0] rand_bits(input int n);
    logic [WW-1:0] v;
    logic          fb;
    int            i;
    v = '0;
    for (i = 0; i < n; i++)
    begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[WW-2:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic add_row(input logic [WW-1:0] l, input logic [WW-1:0] r, input logic rdy,
                         input logic [SW-1:0] el, input logic [SW-1:0] er);
    row_t row;
    row.left24    = l;
    row.right24   = r;
    row.ready     = rdy;
    row.exp.left  = el;
    row.exp.right = er;
    rows.push_back(row);
  endtask

  task automatic build_table();
    logic [WW-1:0] l;
    logic [WW-1:0] r;
    logic [WW-1:0] rdy;
    int            i;
    add_row(24'h123456, 24'hEDCBA9, 1'b1, 16'h1234, 16'hEDCC);  // plain pos / neg
    add_row(24'h000000, 24'h000000, 1'b1, 16'h0000, 16'h0000);  // zero
    add_row(24'h12347F, 24'h123480, 1'b1, 16'h1234, 16'h1235);  // just below / at half
    add_row(24'h7FFF80, 24'h7FFFFF, 1'b1, 16'h7FFF, 16'h7FFF);  // saturating pair
    add_row(24'h800000, 24'hFFFF7F, 1'b1, 16'h8000, 16'hFFFF);  // most negative
    add_row(24'h7FFF7F, 24'hFFFF80, 1'b1, 16'h7FFF, 16'h0000);
    // out_ready low: first DEPTH frames kept, the rest lost
    add_row(24'h010080, 24'hFEFF00, 1'b0, 16'h0101, 16'hFEFF);
    add_row(24'h020000, 24'hFD0000, 1'b0, 16'h0200, 16'hFD00);
    add_row(24'h030000, 24'hFC0000, 1'b0, 16'h0300, 16'hFC00);
    add_row(24'h040000, 24'hFB0000, 1'b0, 16'h0400, 16'hFB00);
    add_row(24'h050000, 24'hFA0000, 1'b0, 16'h0500, 16'hFA00);
    add_row(24'h060000, 24'hF90000, 1'b0, 16'h0600, 16'hF900);
    for (i = N_FIXED; i < N_ROWS; i++)
    begin
      l   = rand_bits(WW);
      r   = rand_bits(WW);
      rdy = rand_bits(1);
      add_row(l, r, rdy[0], round_word(l), round_word(r));
    end
  endtask

  // one slot, entered and left on a falling xclk edge
  task automatic send_slot(input chan_e ch, input logic [WW-1:0] data);
    int k;
    for (k = 0; k < SLOT; k++)
    begin
      bclk = 1'b0;
      if (k == 0)
        lrclk = (ch == RIGHT);  // LRCLK moves with BCLK falling
      if ((k >= 1) && (k <= WW))
        din = data[WW - k];     // msb one bit after the LRCLK edge
      else
        din = 1'b0;
      repeat (4) @(negedge xclk);
      bclk = 1'b1;
      repeat (4) @(negedge xclk);
    end
  endtask

  task automatic check_frame(input string name, input stereo_frame_t got,
                             input stereo_frame_t exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("ERROR %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input logic [7:0] got,
                             input logic [7:0] exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("ERROR %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  // handshake taken at the rising edge, outputs settled since the last one
  always @(posedge xclk)
  begin
    if (!xrst && out_valid)
    begin
      if (exp_q.size() == 0)
      begin
        n_errors++;
        $display("out_valid high at %0t while no frame was expected", $time);
      end
      else if (out_ready)
        check_frame("out_frame", out_frame, exp_q.pop_front());
    end
  end

  // watchdog
  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT)
    begin
      @(posedge xclk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles with %0d frames still expected", cycle_cnt,
             exp_q.size());
    $display("Result: FAILED");
    $finish;
  end

  initial
  begin
    row_t row;
    int   i;
    xrst        = 1'b1;
    bclk        = 1'b0;
    lrclk       = 1'b0;
    din         = 1'b0;
    out_ready   = 1'b1;
    lfsr        = 32'h622e2a9a;
    n_checks    = 0;
    n_errors    = 0;
    exp_overrun = 0;
    occ         = 0;
    build_table();
    repeat (5) @(negedge xclk);
    xrst = 1'b0;

    // stream opens in a right slot, that word has no partner
    send_slot(RIGHT, 24'h5A5A5A);
    repeat (16) @(negedge xclk);
    check_count("overrun_cnt", overrun_cnt, 8'd0);

    for (i = 0; i < rows.size(); i++)
    begin
      row       = rows[i];
      out_ready = row.ready;
      if (row.ready)
        occ = 0;                 // fifo drains during the left slot
      if (occ < DEPTH)
      begin
        exp_q.push_back(row.exp);
        if (!row.ready)
          occ++;
      end
      else
        exp_overrun++;
      send_slot(LEFT, row.left24);
      send_slot(RIGHT, row.right24);
    end

    out_ready = 1'b1;
    while (exp_q.size() != 0)
      @(negedge xclk);
    repeat (20) @(negedge xclk);
    check_count("overrun_cnt", overrun_cnt, (exp_overrun > 255) ? 8'd255 : 8'(exp_overrun));

    $display("checks %0d  errors %0d  overruns expected %0d", n_checks, n_errors, exp_overrun);
    if (n_errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule : codec_rx_tb

`default_nettype wire

/* src.f */
+incdir+hw
hw/codec_rx_pkg.sv
hw/i2s_deserializer.sv
hw/sample_rounder.sv
hw/stereo_framer.sv
hw/frame_fifo.sv
hw/codec_rx_top.sv
verif/codec_rx_tb.sv

/* Bender.yml */
package:
  name: codec_rx

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/codec_rx_pkg.sv
      - hw/i2s_deserializer.sv
      - hw/sample_rounder.sv
      - hw/stereo_framer.sv
      - hw/frame_fifo.sv
      - hw/codec_rx_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/codec_rx_tb.sv
